//--- mul_defines.svh
/*
 * Build-time configuration of the lane-parallel multiply unit.
 * Include it wherever operand widths, lane count or queue depth are needed.
 */
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// Operand width of each lane
`define MUL_WIDTH 16

// Number of lanes handled by one request
`define MUL_LANES 2

// Queue entries, also the issuer's credit count after reset
`define MUL_QUEUE_DEPTH 4

// Width of the request tag carried through to the response
`define MUL_TAG_WIDTH 4

// 1 treats operands as two's complement, 0 as unsigned
`define MUL_SIGNED 1

`endif

//--- mul_pkg.sv
/*
 * Shared types of the multiply unit: opcode, executor states and lane data.
 * Import it with a wildcard import in the module header.
 */
`default_nettype none

`include "mul_defines.svh"

package mul_pkg;

    // Selects which half of each lane product is returned
    typedef enum logic [0:0] {
        op_mul_lo,
        op_mul_hi
    } mul_op_e;

    // Executor sequencing states
    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_run,
        st_done
    } exec_state_e;

    typedef logic [`MUL_LANES-1:0][`MUL_WIDTH-1:0]   lane_data_t;
    typedef logic [`MUL_LANES-1:0][2*`MUL_WIDTH-1:0] lane_prod_t;

endpackage

`default_nettype wire

//--- mul_req_issue.sv
/*
 * Request issuer. Accepts external requests and pushes them into the queue,
 * spending one credit per push and regaining one per credit_return pulse.
 */
`default_nettype none

`include "mul_defines.svh"

module mul_req_issue import mul_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  mul_op_e                   req_op,
    input  logic [`MUL_TAG_WIDTH-1:0] req_tag,
    input  lane_data_t                req_a,
    input  lane_data_t                req_b,
    output logic                      push,
    output mul_op_e                   push_op,
    output logic [`MUL_TAG_WIDTH-1:0] push_tag,
    output lane_data_t                push_a,
    output lane_data_t                push_b,
    input  logic                      credit_return
);
    localparam int CNT_W = $clog2(`MUL_QUEUE_DEPTH + 1);

    logic [CNT_W-1:0] credits_q;

    // Ready as long as one free queue slot is known to exist
    assign req_ready = (credits_q != '0);
    assign push      = req_valid && req_ready;

    assign push_op  = req_op;
    assign push_tag = req_tag;
    assign push_a   = req_a;
    assign push_b   = req_b;

    // A push and a returned credit in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (reset) begin
            credits_q <= CNT_W'(`MUL_QUEUE_DEPTH);
        end else begin
            case ({push, credit_return})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- mul_req_queue.sv
/*
 * Circular buffer of pending multiply requests between issuer and executor.
 * Presents the head entry and returns one credit to the issuer per pop.
 */
`default_nettype none

`include "mul_defines.svh"

module mul_req_queue import mul_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      push,
    input  mul_op_e                   push_op,
    input  logic [`MUL_TAG_WIDTH-1:0] push_tag,
    input  lane_data_t                push_a,
    input  lane_data_t                push_b,
    output logic                      q_valid,
    output mul_op_e                   q_op,
    output logic [`MUL_TAG_WIDTH-1:0] q_tag,
    output lane_data_t                q_a,
    output lane_data_t                q_b,
    input  logic                      pop,
    output logic                      credit_return
);
    localparam int DEPTH = `MUL_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mul_op_e                   op_mem  [DEPTH];
    logic [`MUL_TAG_WIDTH-1:0] tag_mem [DEPTH];
    lane_data_t                a_mem   [DEPTH];
    lane_data_t                b_mem   [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr_q]  <= push_op;
            tag_mem[wr_ptr_q] <= push_tag;
            a_mem[wr_ptr_q]   <= push_a;
            b_mem[wr_ptr_q]   <= push_b;
        end
    end

    // Pointers wrap explicitly so the depth need not be a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign q_valid = (count_q != '0);
    assign q_op    = op_mem[rd_ptr_q];
    assign q_tag   = tag_mem[rd_ptr_q];
    assign q_a     = a_mem[rd_ptr_q];
    assign q_b     = b_mem[rd_ptr_q];

    // Every popped slot becomes free again for the issuer
    assign credit_return = pop;

endmodule

`default_nettype wire

//--- serial_mul.sv
/*
 * Iterative shift-and-add multiplier for several lanes in parallel.
 * Pulse strobe with the operands loaded; busy stays high for WIDTH cycles
 * and result holds the full products until the next strobe.
 */
`default_nettype none

module serial_mul #(
    parameter int WIDTH  = 16,
    parameter int LANES  = 1,
    parameter int SIGNED = 0
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            strobe,
    output logic                            busy,
    input  logic [LANES-1:0][WIDTH-1:0]     dataa,
    input  logic [LANES-1:0][WIDTH-1:0]     datab,
    output logic [LANES-1:0][2*WIDTH-1:0]   result
);
    localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [CNT_W-1:0] cntr_q;
    logic             busy_q;

    // One counter paces all lanes at one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            cntr_q <= '0;
        end else if (strobe) begin
            busy_q <= 1'b1;
            cntr_q <= CNT_W'(WIDTH - 1);
        end else if (busy_q) begin
            cntr_q <= cntr_q - 1'b1;
            if (cntr_q == '0) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign busy = busy_q;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic [WIDTH-1:0]   a_q;
        logic [WIDTH-1:0]   b_q;
        logic [2*WIDTH-1:0] p_q;
        logic [WIDTH-1:0]   axb;
        logic [WIDTH:0]     addend;

        // Partial product of the multiplier bit currently at the bottom of b_q
        assign axb = b_q[0] ? a_q : '0;

        if (SIGNED != 0) begin : g_signed
            localparam logic [2*WIDTH-1:0] CORR =
                {1'b1, {(WIDTH-2){1'b0}}, 1'b1, {WIDTH{1'b0}}};

            // In Baugh-Wooley form the sign row is negated and other rows flip their top bit
            assign addend = (cntr_q == '0) ?
                {1'b0, axb[WIDTH-1], ~axb[WIDTH-2:0]} :
                {1'b0, ~axb[WIDTH-1], axb[WIDTH-2:0]};
            assign result[i] = p_q + CORR;
        end else begin : g_unsigned
            assign addend    = {1'b0, axb};
            assign result[i] = p_q;
        end

        // Add into the upper half and shift the whole product right in one step
        always_ff @(posedge clk) begin
            if (strobe) begin
                a_q <= dataa[i];
                b_q <= datab[i];
                p_q <= '0;
            end else if (busy_q) begin
                b_q                      <= b_q >> 1;
                p_q[WIDTH-2:0]           <= p_q[WIDTH-1:1];
                p_q[2*WIDTH-1:WIDTH-1]   <= {1'b0, p_q[2*WIDTH-1:WIDTH]} + addend;
            end
        end
    end

endmodule

`default_nettype wire

//--- mul_exec.sv
/*
 * Multiply executor. Pops one request at a time, runs it on the serial
 * multiplier and holds the selected product halves until the response is taken.
 */
`default_nettype none

`include "mul_defines.svh"

module mul_exec import mul_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      q_valid,
    input  mul_op_e                   q_op,
    input  logic [`MUL_TAG_WIDTH-1:0] q_tag,
    input  lane_data_t                q_a,
    input  lane_data_t                q_b,
    output logic                      pop,
    output logic                      resp_valid,
    input  logic                      resp_ready,
    output logic [`MUL_TAG_WIDTH-1:0] resp_tag,
    output lane_data_t                resp_data
);
    exec_state_e               state_q;
    exec_state_e               state_d;
    mul_op_e                   op_q;
    logic [`MUL_TAG_WIDTH-1:0] tag_q;
    lane_data_t                a_q;
    lane_data_t                b_q;
    logic                      strobe;
    logic                      busy;
    lane_prod_t                prod;

    assign pop    = (state_q == st_idle) && q_valid;
    assign strobe = (state_q == st_start);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:  if (q_valid) state_d = st_start;
            st_start: state_d = st_run;
            // Busy is already high in the first run cycle
            st_run:   if (!busy) state_d = st_done;
            st_done:  if (resp_ready) state_d = st_idle;
            default:  state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Request payload is captured on pop since the queue head moves on
    always_ff @(posedge clk) begin
        if (pop) begin
            op_q  <= q_op;
            tag_q <= q_tag;
            a_q   <= q_a;
            b_q   <= q_b;
        end
    end

    serial_mul #(
        .WIDTH  (`MUL_WIDTH),
        .LANES  (`MUL_LANES),
        .SIGNED (`MUL_SIGNED)
    ) serial_mul_i (
        .clk    (clk),
        .reset  (reset),
        .strobe (strobe),
        .busy   (busy),
        .dataa  (a_q),
        .datab  (b_q),
        .result (prod)
    );

    assign resp_valid = (state_q == st_done);
    assign resp_tag   = tag_q;

    always_comb begin
        for (int i = 0; i < `MUL_LANES; i++) begin
            if (op_q == op_mul_hi) begin
                resp_data[i] = prod[i][2*`MUL_WIDTH-1:`MUL_WIDTH];
            end else begin
                resp_data[i] = prod[i][`MUL_WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- mul_unit_top.sv
/*
 * Top level of the lane-parallel multiply unit.
 * Requests pass issuer, credit-controlled queue and executor in order.
 */
`default_nettype none

`include "mul_defines.svh"

module mul_unit_top import mul_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  mul_op_e                   req_op,
    input  logic [`MUL_TAG_WIDTH-1:0] req_tag,
    input  lane_data_t                req_a,
    input  lane_data_t                req_b,
    output logic                      resp_valid,
    input  logic                      resp_ready,
    output logic [`MUL_TAG_WIDTH-1:0] resp_tag,
    output lane_data_t                resp_data
);
    // Issuer to queue
    logic                      push;
    mul_op_e                   push_op;
    logic [`MUL_TAG_WIDTH-1:0] push_tag;
    lane_data_t                push_a;
    lane_data_t                push_b;
    logic                      credit_return;

    // Queue to executor
    logic                      q_valid;
    mul_op_e                   q_op;
    logic [`MUL_TAG_WIDTH-1:0] q_tag;
    lane_data_t                q_a;
    lane_data_t                q_b;
    logic                      pop;

    mul_req_issue mul_req_issue_i (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_op        (req_op),
        .req_tag       (req_tag),
        .req_a         (req_a),
        .req_b         (req_b),
        .push          (push),
        .push_op       (push_op),
        .push_tag      (push_tag),
        .push_a        (push_a),
        .push_b        (push_b),
        .credit_return (credit_return)
    );

    mul_req_queue mul_req_queue_i (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .push_op       (push_op),
        .push_tag      (push_tag),
        .push_a        (push_a),
        .push_b        (push_b),
        .q_valid       (q_valid),
        .q_op          (q_op),
        .q_tag         (q_tag),
        .q_a           (q_a),
        .q_b           (q_b),
        .pop           (pop),
        .credit_return (credit_return)
    );

    mul_exec mul_exec_i (
        .clk        (clk),
        .reset      (reset),
        .q_valid    (q_valid),
        .q_op       (q_op),
        .q_tag      (q_tag),
        .q_a        (q_a),
        .q_b        (q_b),
        .pop        (pop),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_tag   (resp_tag),
        .resp_data  (resp_data)
    );

endmodule

`default_nettype wire

//--- tb_mul_unit.sv
/*
 * Directed testbench of the multiply unit. Drives requests through the top
 * level, models every lane product independently and checks responses in order.
 */
`default_nettype none

`include "mul_defines.svh"

module tb_mul_unit import mul_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W       = `MUL_WIDTH;
    localparam int TIMEOUT = 400;

    logic                      clk;
    logic                      reset;
    logic                      req_valid;
    logic                      req_ready;
    mul_op_e                   req_op;
    logic [`MUL_TAG_WIDTH-1:0] req_tag;
    lane_data_t                req_a;
    lane_data_t                req_b;
    logic                      resp_valid;
    logic                      resp_ready;
    logic [`MUL_TAG_WIDTH-1:0] resp_tag;
    lane_data_t                resp_data;

    logic [`MUL_TAG_WIDTH-1:0] exp_tag[$];
    lane_data_t                exp_data[$];
    logic [31:0]               lfsr_q;
    string                     cur_test;

    mul_unit_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_tag    (req_tag),
        .req_a      (req_a),
        .req_b      (req_b),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_tag   (resp_tag),
        .resp_data  (resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // Each lane is the signed product of two W-bit words and the opcode picks its half
    function automatic lane_data_t model_lanes(input mul_op_e op, input lane_data_t a,
                                               input lane_data_t b);
        lane_data_t            r;
        logic signed [2*W-1:0] p;
        for (int i = 0; i < `MUL_LANES; i++) begin
            p    = $signed({{W{a[i][W-1]}}, a[i]}) * $signed({{W{b[i][W-1]}}, b[i]});
            r[i] = (op == op_mul_hi) ? p[2*W-1:W] : p[W-1:0];
        end
        return r;
    endfunction

    task automatic check_response();
        logic [`MUL_TAG_WIDTH-1:0] tag;
        lane_data_t                data;
        assert (exp_tag.size() != 0) else
            abort_run($sformatf("%s: a response came out with no request outstanding",
                                cur_test));
        tag  = exp_tag.pop_front();
        data = exp_data.pop_front();
        assert (resp_tag == tag) else
            abort_run($sformatf("Fail %s: tag expected %0h actual %0h", cur_test, tag,
                                resp_tag));
        assert (resp_data == data) else
            abort_run($sformatf("Fail %s: data expected %h actual %h", cur_test, data,
                                resp_data));
    endtask

    // Handshakes are judged at the falling edge and inputs change just after the rise
    task automatic clock_cycle(output logic accepted);
        @(negedge clk);
        if (resp_valid && resp_ready) begin
            check_response();
        end
        accepted = req_valid && req_ready;
        if (accepted) begin
            exp_tag.push_back(req_tag);
            exp_data.push_back(model_lanes(req_op, req_a, req_b));
        end
        @(posedge clk);
        #2;
    endtask

    task automatic send_request(input mul_op_e op, input logic [`MUL_TAG_WIDTH-1:0] tag,
                                input lane_data_t a, input lane_data_t b);
        logic acc;
        int   waited;
        req_valid = 1'b1;
        req_op    = op;
        req_tag   = tag;
        req_a     = a;
        req_b     = b;
        acc       = 1'b0;
        waited    = 0;
        while (!acc) begin
            clock_cycle(acc);
            waited++;
            if (!acc && waited > TIMEOUT) begin
                abort_run($sformatf("%s: request was never accepted", cur_test));
            end
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        logic acc;
        int   waited;
        waited = 0;
        while (exp_tag.size() != 0) begin
            clock_cycle(acc);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("%s: responses did not arrive in time", cur_test));
            end
        end
    endtask

    task automatic load_random_request(input int tag);
        req_op  = mul_op_e'(take_bits(1));
        req_tag = `MUL_TAG_WIDTH'(tag);
        for (int i = 0; i < `MUL_LANES; i++) begin
            req_a[i] = W'(take_bits(W));
            req_b[i] = W'(take_bits(W));
        end
    endtask

    function automatic logic [W-1:0] corner_value(input int i);
        case (i % 8)
            0:       return W'(0);
            1:       return W'(1);
            2:       return {1'b0, {(W-1){1'b1}}};
            3:       return {1'b1, {(W-1){1'b0}}};
            4:       return {W{1'b1}};
            5:       return W'(16'h1234);
            6:       return W'(16'hfedc);
            default: return W'(2);
        endcase
    endfunction

    task automatic check_idle_after_reset();
        cur_test = "reset";
        @(negedge clk);
        assert (req_ready === 1'b1) else
            abort_run($sformatf("Fail %s: req_ready expected 1 actual %b", cur_test, req_ready));
        assert (resp_valid === 1'b0) else
            abort_run($sformatf("Fail %s: resp_valid expected 0 actual %b", cur_test,
                                resp_valid));
        @(posedge clk);
        #2;
    endtask

    task automatic directed_products(input mul_op_e op, input string name);
        lane_data_t a;
        lane_data_t b;
        cur_test   = name;
        resp_ready = 1'b1;
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 8; k++) begin
                a[0] = corner_value(i);
                b[0] = corner_value(i + k);
                a[1] = corner_value(7 - i);
                b[1] = corner_value(i + k + 1);
                send_request(op, `MUL_TAG_WIDTH'(i * 8 + k), a, b);
            end
        end
        wait_drained();
    endtask

    // The queue fills behind a stalled executor until the credits run out
    task automatic backpressure_fill();
        logic acc;
        int   n_acc;
        cur_test   = "backpressure";
        resp_ready = 1'b0;
        n_acc      = 0;
        load_random_request(0);
        req_valid = 1'b1;
        for (int c = 0; c < 4 * W; c++) begin
            clock_cycle(acc);
            if (acc) begin
                n_acc++;
                load_random_request(n_acc);
            end
        end
        req_valid = 1'b0;
        assert (n_acc == `MUL_QUEUE_DEPTH + 1) else
            abort_run($sformatf("Fail %s: accepted expected %0d actual %0d", cur_test,
                                `MUL_QUEUE_DEPTH + 1, n_acc));
        assert (req_ready == 1'b0) else
            abort_run($sformatf("Fail %s: req_ready expected 0 actual %b", cur_test, req_ready));
        resp_ready = 1'b1;
        wait_drained();
    endtask

    task automatic random_stream();
        logic acc;
        int   n_sent;
        int   waited;
        cur_test   = "random";
        n_sent     = 0;
        waited     = 0;
        load_random_request(0);
        req_valid  = 1'b1;
        resp_ready = (take_bits(2) != '0);
        while (n_sent < 40 || exp_tag.size() != 0) begin
            clock_cycle(acc);
            if (acc) begin
                n_sent++;
                if (n_sent < 40) begin
                    load_random_request(n_sent);
                end else begin
                    req_valid = 1'b0;
                end
            end
            resp_ready = (take_bits(2) != '0);
            waited++;
            if (waited > 40 * TIMEOUT) begin
                abort_run($sformatf("%s: stream did not complete in time", cur_test));
            end
        end
        resp_ready = 1'b1;
        // A duplicated response would still come out after the last expected one
        for (int c = 0; c < 2 * W; c++) begin
            clock_cycle(acc);
        end
    endtask

    initial begin
        lfsr_q     = 32'h9c2d_6d34;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_op     = op_mul_lo;
        req_tag    = '0;
        req_a      = '0;
        req_b      = '0;
        resp_ready = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        check_idle_after_reset();
        directed_products(op_mul_lo, "low_half");
        directed_products(op_mul_hi, "high_half");
        backpressure_fill();
        random_stream();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
mul_pkg.sv
mul_req_issue.sv
mul_req_queue.sv
serial_mul.sv
mul_exec.sv
mul_unit_top.sv
tb_mul_unit.sv

//--- Bender.yml
package:
  name: mul_unit

sources:
  - include_dirs:
      - .
    files:
      - mul_pkg.sv
      - mul_req_issue.sv
      - mul_req_queue.sv
      - serial_mul.sv
      - mul_exec.sv
      - mul_unit_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mul_unit.sv
